// File: filelist.f
+incdir+verilog
verilog/sm83Pkg.sv
verilog/sm83Alu.sv
verilog/sm83Core.sv
verilog/irqRegs.sv
verilog/irqChannel.sv
verilog/irqPriority.sv
verilog/sm83Subsystem.sv
test/tbClock.sv
test/tbSm83.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SM83 subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tbSm83 -o simSm83
./obj_dir/simSm83 > sim.log
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "Testbench reported failure, see sim.log"
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	echo "No result line in sim.log"
	exit 1
fi
exit 0

// File: test/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic CLK
);

	// 10 ns period, first rising edge at 5 ns
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

endmodule

// File: test/tbSm83.sv
`timescale 1ns/1ps
`include "sm83_macros.svh"

module tbSm83;

	localparam int STEPS = 79; // Reset 1, chains 64, branches 8, regs 1, irq rounds 4, halt 1
	localparam logic [2:0] ALU_YS [6] = '{3'd0, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};

	logic        CLK;
	logic        rst;
	logic [7:0]  dataIn;
	logic [7:0]  irqTrig;
	logic [15:0] addr;
	logic [7:0]  dataOut;
	logic        rd;
	logic        wr;
	logic        m1;
	logic        halted;
	logic [7:0]  irqAck;

	logic [7:0]       mem [0:65535]; // Program and data, answers same cycle
	logic [31:0]      lfsr;
	sm83Pkg::busReq_t wQ[$];         // Expected outside writes, in order
	logic [7:0]       aQ[$];         // Expected acknowledges, in order
	logic [15:0]      asmPc;         // Assembler location counter
	int               errors;
	int               errBefore;
	int               testsRun;
	int               testsFailed;
	logic             vecDue;        // Next m1 must hit the vector
	logic [15:0]      vecAddr;

	tbClock clkGen (.CLK(CLK));

	sm83Subsystem dut (
		.CLK(CLK), .rst(rst), .dataIn(dataIn), .irqTrig(irqTrig),
		.addr(addr), .dataOut(dataOut), .rd(rd), .wr(wr), .m1(m1),
		.halted(halted), .irqAck(irqAck)
	);

	assign dataIn = rd ? mem[addr] : 8'h00; // Combinational, only under rd

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1); // Galois taps 32,30,26,25
	endfunction

	function logic [7:0] takeBits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], lfsr[0]}; // One step per bit
			lfsr = lfsrNext(lfsr);
		end
		return r;
	endfunction

	// Expected {z,n,h,c,result} for an immediate ALU op selected by y
	function automatic logic [11:0] refAlu(input logic [2:0] y, input logic [7:0] a,
		input logic [7:0] b);
		logic [7:0] r;
		logic n;
		logic h;
		logic c;
		n = 1'b0;
		h = 1'b0;
		c = 1'b0;
		case (y)
			3'd0: begin
				r = a + b;
				h = (int'(a[3:0]) + int'(b[3:0])) > 15;
				c = (int'(a) + int'(b)) > 255;
			end
			3'd2, 3'd7: begin
				r = a - b; // CP same flags as SUB
				n = 1'b1;
				h = b[3:0] > a[3:0];
				c = b > a;
			end
			3'd4: begin
				r = a & b;
				h = 1'b1;
			end
			3'd5: r = a ^ b;
			3'd6: r = a | b;
			default: r = a;
		endcase
		return {r == 8'd0, n, h, c, r};
	endfunction

	task automatic emit(input logic [7:0] b);
		mem[asmPc] = b;
		asmPc = asmPc + 16'd1;
	endtask

	task automatic emit3(input logic [7:0] op, input logic [15:0] a16);
		emit(op);
		emit(a16[7:0]); // Little endian operand
		emit(a16[15:8]);
	endtask

	task automatic expectWrite(input logic [15:0] a, input logic [7:0] d);
		sm83Pkg::busReq_t e;
		e = '0;
		e.addr = a;
		e.wdata = d;
		e.wr = 1'b1;
		wQ.push_back(e);
	endtask

	task automatic checkWrite(input sm83Pkg::busReq_t exp, input sm83Pkg::busReq_t got);
		if (got !== exp) begin
			$display("[FAIL] write addr exp %h got %h, dataOut exp %h got %h",
				exp.addr, got.addr, exp.wdata, got.wdata);
			errors++;
		end
	endtask

	task automatic checkAck(input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp) begin
			$display("[FAIL] irqAck exp %h got %h", exp, got);
			errors++;
		end
	endtask

	task automatic beginTest();
		@(posedge CLK);
		#1 rst = 1'b1;
		irqTrig = '0;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8); // Depends on every address bit
		wQ.delete();
		aQ.delete();
		asmPc = `RESET_PC;
		errBefore = errors;
	endtask

	task automatic releaseReset();
		repeat (5) @(posedge CLK);
		#1 rst = 1'b0;
	endtask

	task automatic pulse(input logic [7:0] lines);
		@(posedge CLK);
		#1 irqTrig = lines;
		@(posedge CLK);
		#1 irqTrig = '0;
	endtask

	// Done when all expectations are met and the core spins at endAddr
	task automatic endTest(input int num, input string name, input logic [15:0] endAddr);
		do @(negedge CLK); while (!(wQ.size() == 0 && aQ.size() == 0 && m1 && addr == endAddr));
		testsRun++;
		if (errors != errBefore) begin
			testsFailed++;
			$display("Test %0d %s: %0d mismatches", num, name, errors - errBefore);
		end else begin
			$display("Test %0d %s: ok", num, name);
		end
	endtask

	// Outputs sampled mid-cycle, where they are stable
	always @(negedge CLK) begin
		logic [7:0] e;
		if (rst) begin
			vecDue = 1'b0;
		end else begin
			if (wr) begin
				mem[addr] = dataOut;
				if (wQ.size() == 0) begin
					$display("Unexpected write to address %h", addr);
					errors++;
				end else begin
					checkWrite(wQ.pop_front(), {addr, dataOut, rd, wr, m1});
				end
			end
			if (m1 && vecDue) begin
				if (addr !== vecAddr) begin
					$display("[FAIL] addr at vector fetch exp %h got %h", vecAddr, addr);
					errors++;
				end
				vecDue = 1'b0;
			end
			if (irqAck != '0) begin
				if (aQ.size() == 0) begin
					$display("Acknowledge %h seen with no interrupt expected", irqAck);
					errors++;
				end else begin
					e = aQ.pop_front();
					checkAck(e, irqAck);
					vecDue = 1'b1;
					for (int i = 0; i < 8; i++)
						if (e[i])
							vecAddr = `VECTOR_BASE + 16'(8 * i);
				end
			end
		end
	end

	initial begin
		#(STEPS * 200 * 10);
		$display("Watchdog timeout after %0d cycles", STEPS * 200);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		logic [11:0] r;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  ie;
		logic [7:0]  p;
		logic [2:0]  y;
		logic [15:0] base;
		logic [15:0] dst;
		logic [15:0] endAddr;
		int          n;
		rst = 1'b1;
		irqTrig = '0;
		lfsr = 32'h20fa50bf;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;

		beginTest();
		emit3(8'hC3, `RESET_PC); // Spin at 0
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		if ({rd, wr, m1, halted, irqAck} !== '0) begin
			$display("[FAIL] rd/wr/m1/halted/irqAck in reset exp 0 got %h",
				{rd, wr, m1, halted, irqAck});
			errors++;
		end
		@(posedge CLK);
		#1 rst = 1'b0;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (!m1 && n < 4);
		if (!m1) begin
			$display("No opcode fetch within 4 cycles of reset release");
			errors++;
		end else if (addr !== `RESET_PC) begin
			$display("[FAIL] addr of first fetch exp %h got %h", `RESET_PC, addr);
			errors++;
		end
		endTest(1, "reset", `RESET_PC);

		beginTest();
		for (int k = 0; k < 64; k++) begin
			a = takeBits(8);
			b = takeBits(8);
			y = ALU_YS[takeBits(3) % 6];
			emit(8'h3E);
			emit(a);
			emit({2'b11, y, 3'b110}); // Immediate ALU op
			emit(b);
			emit3(8'hEA, 16'hC000 + 16'(k));
			r = refAlu(y, a, b);
			expectWrite(16'hC000 + 16'(k), (y == 3'd7) ? a : r[7:0]); // CP keeps A
		end
		endAddr = asmPc;
		emit3(8'hC3, endAddr);
		releaseReset();
		endTest(2, "alu chains", endAddr);

		beginTest();
		dst = '0;
		for (int k = 0; k < 8; k++) begin
			base = asmPc;
			a = takeBits(8);
			b = takeBits(1) ? a : takeBits(8); // Half the compares hit Z
			r = refAlu(3'd7, a, b);
			emit(8'h3E);
			emit(a);
			emit(8'hFE);
			emit(b);
			emit3(8'hCA, base + 16'd16);
			emit3(8'hDA, base + 16'd22);
			emit3(8'hEA, 16'hD000 + 16'(3 * k));
			emit3(8'hC3, base + 16'd25);
			emit3(8'hEA, 16'hD001 + 16'(3 * k));
			emit3(8'hC3, base + 16'd25);
			emit3(8'hEA, 16'hD002 + 16'(3 * k));
			dst = 16'hD000 + 16'(3 * k) + (r[11] ? 16'd1 : (r[8] ? 16'd2 : 16'd0));
			expectWrite(dst, a);
		end
		emit(8'h3E);
		emit(~a); // Clobber A before the reload
		emit3(8'hFA, dst);
		emit3(8'hEA, 16'hD100);
		expectWrite(16'hD100, a);
		endAddr = asmPc;
		emit3(8'hC3, endAddr);
		releaseReset();
		endTest(3, "branches and load", endAddr);

		beginTest();
		a = takeBits(8);
		b = takeBits(8);
		emit(8'h3E);
		emit(a);
		emit3(8'hEA, `IE_ADDR);
		emit(8'h3E);
		emit(b);
		emit3(8'hEA, `IF_ADDR);
		emit3(8'hFA, `IE_ADDR);
		emit3(8'hEA, 16'hC100);
		emit3(8'hFA, `IF_ADDR);
		emit3(8'hEA, 16'hC101);
		expectWrite(`IE_ADDR, a);
		expectWrite(`IF_ADDR, b);
		expectWrite(16'hC100, a);
		expectWrite(16'hC101, b); // No triggers, IF reads back as written
		endAddr = asmPc;
		emit3(8'hC3, endAddr);
		releaseReset();
		endTest(4, "IE and IF registers", endAddr);

		beginTest();
		ie = takeBits(8) | 8'h01;
		emit3(8'hC3, 16'h0100);
		for (int i = 0; i < 8; i++) begin
			asmPc = `VECTOR_BASE + 16'(8 * i);
			emit(8'h00); // Handler leaves A alone
			emit(8'hD9);
		end
		asmPc = 16'h0100;
		emit(8'h3E);
		emit(ie);
		emit3(8'hEA, `IE_ADDR);
		emit(8'hFB);
		expectWrite(`IE_ADDR, ie);
		for (int k = 0; k < 48; k++) begin
			emit(8'h3E);
			emit(8'(k));
			emit3(8'hEA, 16'hC200 + 16'(k));
			expectWrite(16'hC200 + 16'(k), 8'(k));
		end
		endAddr = asmPc;
		emit3(8'hC3, endAddr);
		releaseReset();
		for (int round = 0; round < 4; round++) begin
			repeat (20) @(posedge CLK);
			p = takeBits(8);
			if ((p & ie) == '0)
				p = ie;
			for (int i = 0; i < 8; i++)
				if (p[i] && ie[i])
					aQ.push_back(8'(1 << i)); // Served lowest line first
			pulse(p);
			do @(negedge CLK); while (aQ.size() != 0);
		end
		endTest(5, "interrupt dispatch", endAddr);

		beginTest();
		ie = takeBits(7) | 8'h01; // Line 7 stays disabled
		a = takeBits(8);
		emit(8'h3E);
		emit(ie);
		emit3(8'hEA, `IE_ADDR);
		emit(8'h76);
		emit(8'h3E);
		emit(a);
		emit3(8'hEA, 16'hC400);
		expectWrite(`IE_ADDR, ie);
		expectWrite(16'hC400, a);
		endAddr = asmPc;
		emit3(8'hC3, endAddr);
		releaseReset();
		do @(negedge CLK); while (!halted);
		repeat (10) @(negedge CLK);
		pulse(8'h80);
		repeat (5) @(negedge CLK);
		if (!halted) begin
			$display("Core left HALT without an enabled line pending");
			errors++;
		end
		pulse(8'h01);
		endTest(6, "halt wakeup", endAddr);

		$display("Tests: %0d run, %0d failed, %0d mismatches", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: verilog/irqChannel.sv
`timescale 1ns/1ps

module irqChannel (
	input  logic CLK,
	input  logic rst,
	input  logic trig,    // Raw request line
	input  logic ifWrite, // IF register store
	input  logic ifWbit,  // This line's bit of the store
	input  logic ack,     // Dispatch taken on this line
	output logic pending
);

	logic trigPrev; // Last sampled trig
	logic flag;     // IF bit

	// Edge detect history, sampled every cycle
	always_ff @(posedge CLK) begin
		trigPrev <= trig;
	end

	always_ff @(posedge CLK) begin
		if (rst)
			flag <= 1'b0;
		else if (trig && !trigPrev)
			flag <= 1'b1; // New edge beats write and ack
		else if (ifWrite)
			flag <= ifWbit; // Software set or clear
		else if (ack)
			flag <= 1'b0;
	end

	assign pending = flag;

endmodule

// File: verilog/irqPriority.sv
`timescale 1ns/1ps
`include "sm83_macros.svh"

module irqPriority (
	input  logic [`IRQ_LINES-1:0] pending,
	input  logic [`IRQ_LINES-1:0] ieBits,
	input  logic                  irqTaken, // Core ack cycle
	output sm83Pkg::irqVec_t      irq,
	output logic                  wakeAny,
	output logic [`IRQ_LINES-1:0] ack       // One-hot, only with irqTaken
);

	logic [`IRQ_LINES-1:0] active; // Pending and enabled

	assign active = pending & ieBits;
	assign wakeAny = |active; // HALT exit ignores IME

	// Scan down so the lowest set line is written last
	always_comb begin
		irq = '0;
		for (int i = `IRQ_LINES - 1; i >= 0; i--) begin
			if (active[i]) begin
				irq.req = 1'b1;
				irq.line = 3'(i);
			end
		end
	end

	always_comb begin
		ack = '0;
		if (irqTaken && irq.req)
			ack[irq.line] = 1'b1;
	end

endmodule

// File: verilog/irqRegs.sv
`timescale 1ns/1ps
`include "sm83_macros.svh"

module irqRegs (
	input  logic                   CLK,
	input  logic                   rst,
	input  sm83Pkg::busReq_t       bus,
	input  logic [`IRQ_LINES-1:0]  ifBits,  // Channel flags
	output logic [`IRQ_LINES-1:0]  ieBits,
	output logic                   ifWrite, // Store to IF this cycle
	output logic [`IRQ_LINES-1:0]  ifWdata,
	output logic                   hit,     // Read served here, not memory
	output logic [7:0]             rdata
);

	logic ieSel; // Address decodes to IE
	logic ifSel; // Address decodes to IF

	assign ieSel = (bus.addr == `IE_ADDR);
	assign ifSel = (bus.addr == `IF_ADDR);
	assign hit = (ieSel || ifSel) && bus.rd;
	assign ifWrite = ifSel && bus.wr;
	assign ifWdata = bus.wdata[`IRQ_LINES-1:0]; // One bit per channel

	// IE lives here, IF bits live in the channels
	always_ff @(posedge CLK) begin
		if (rst)
			ieBits <= '0;
		else if (ieSel && bus.wr)
			ieBits <= bus.wdata[`IRQ_LINES-1:0];
	end

	always_comb begin
		if (ieSel)
			rdata = ieBits;
		else
			rdata = ifBits; // Only consumed when hit
	end

endmodule

// File: verilog/sm83Alu.sv
`timescale 1ns/1ps

module sm83Alu (
	input  sm83Pkg::aluOp_t    op,   // Operation from opcode y field
	input  logic [7:0]         a,    // Accumulator
	input  logic [7:0]         b,    // Immediate operand
	input  logic               cin,  // Carry in, borrow in for SUB/CP
	output logic [7:0]         res,
	output sm83Pkg::aluFlags_t flags
);

	logic [8:0] sum;    // Full result with carry/borrow in bit 8
	logic [4:0] lowSum; // Low nibble for the half carry

	always_comb begin
		sum = 9'd0;
		lowSum = 5'd0;
		res = a;
		flags = '0;
		case (op)
			sm83Pkg::ALU_ADD: begin
				sum = {1'b0, a} + {1'b0, b} + {8'd0, cin};
				lowSum = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
				res = sum[7:0];
				flags.h = lowSum[4]; // Carry out of bit 3
				flags.c = sum[8];
			end
			sm83Pkg::ALU_SUB, sm83Pkg::ALU_CP: begin
				// CP computes the same difference, core drops res
				sum = {1'b0, a} - {1'b0, b} - {8'd0, cin};
				lowSum = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
				res = sum[7:0];
				flags.n = 1'b1;
				flags.h = lowSum[4]; // Borrow wraps into bit 4
				flags.c = sum[8];    // Borrow from bit 8
			end
			sm83Pkg::ALU_AND: begin
				res = a & b;
				flags.h = 1'b1; // SM83 sets H on AND
			end
			sm83Pkg::ALU_XOR: begin
				res = a ^ b;
			end
			sm83Pkg::ALU_OR: begin
				res = a | b;
			end
			default: begin
				res = a; // Not reached for decoded ops
			end
		endcase
		flags.z = (res == 8'd0); // Z from every op
	end

endmodule

// File: verilog/sm83Core.sv
`timescale 1ns/1ps
`include "sm83_macros.svh"

module sm83Core (
	input  logic              CLK,
	input  logic              rst,
	input  logic [7:0]        rdata,   // Read data, same cycle as rd
	input  sm83Pkg::irqVec_t  irq,     // Request and line from encoder
	input  logic              wakeAny, // Enabled line pending, ends HALT
	output sm83Pkg::busReq_t  bus,
	output logic              irqTaken, // Acknowledge cycle
	output logic              halted
);

	localparam logic [7:0] OP_LD_A_N   = 8'h3E;
	localparam logic [7:0] OP_LD_MEM_A = 8'hEA; // LD (a16),A
	localparam logic [7:0] OP_LD_A_MEM = 8'hFA; // LD A,(a16)
	localparam logic [7:0] OP_JP       = 8'hC3;
	localparam logic [7:0] OP_JP_Z     = 8'hCA;
	localparam logic [7:0] OP_JP_C     = 8'hDA;
	localparam logic [7:0] OP_HALT     = 8'h76;
	localparam logic [7:0] OP_EI       = 8'hFB;
	localparam logic [7:0] OP_DI       = 8'hF3;
	localparam logic [7:0] OP_RETI     = 8'hD9;

	typedef enum logic [3:0] {
		S_BOOT,  // Idle out of reset
		S_FETCH, // Opcode fetch, or interrupt ack
		S_IMM,   // 8-bit immediate
		S_LO,    // Address/target low byte
		S_HI,    // Address/target high byte
		S_MEM,   // Data load or store
		S_JUMP,  // Internal cycle of a taken JP
		S_HALT,  // Waiting for a pending line
		S_VEC    // Load the vector
	} state_t;

	state_t              state;
	state_t              nextState;
	logic [15:0]         pc;
	logic [15:0]         shadowPc; // Return address for RETI
	logic [15:0]         tgt;      // a16 operand
	logic [15:0]         vector;
	logic [7:0]          accA;
	sm83Pkg::aluFlags_t  flags;
	logic                ime;
	sm83Pkg::opcode_u    ir;       // Opcode being executed
	sm83Pkg::opcode_u    fetchOp;  // Opcode on the bus now
	logic [2:0]          vecLine;  // Line taken at ack
	logic                dispatch;
	logic                jpTaken;
	sm83Pkg::aluOp_t     aluOp;
	logic [7:0]          aluRes;
	sm83Pkg::aluFlags_t  aluFlags;

	// Group 3, z=6, minus ADC and SBC
	function automatic logic isAluImm(input sm83Pkg::opcode_u o);
		return (o.f.x == 2'd3) && (o.f.z == 3'd6) && (o.f.y != 3'd1) && (o.f.y != 3'd3);
	endfunction

	assign fetchOp.raw = rdata;
	assign dispatch = (state == S_FETCH) && ime && irq.req; // Only at instruction boundary
	assign aluOp = sm83Pkg::aluOp_t'(ir.f.y);
	assign vector = `VECTOR_BASE + {10'd0, vecLine, 3'b000}; // 8 bytes per line
	assign halted = (state == S_HALT);

	// Conditions read the stored flags
	assign jpTaken = (ir.raw == OP_JP) ||
		((ir.raw == OP_JP_Z) && flags.z) ||
		((ir.raw == OP_JP_C) && flags.c);

	sm83Alu alu (
		.op(aluOp),
		.a(accA),
		.b(rdata),
		.cin(1'b0), // No ADC/SBC in this subset
		.res(aluRes),
		.flags(aluFlags)
	);

	always_comb begin
		nextState = state;
		case (state)
			S_BOOT: nextState = S_FETCH;
			S_FETCH: begin
				if (dispatch) begin
					nextState = S_VEC; // This cycle was the ack
				end else if ((fetchOp.raw == OP_LD_A_N) || isAluImm(fetchOp)) begin
					nextState = S_IMM;
				end else if ((fetchOp.raw == OP_LD_MEM_A) || (fetchOp.raw == OP_LD_A_MEM) ||
					(fetchOp.raw == OP_JP) || (fetchOp.raw == OP_JP_Z) ||
					(fetchOp.raw == OP_JP_C)) begin
					nextState = S_LO;
				end else if (fetchOp.raw == OP_HALT) begin
					nextState = S_HALT;
				end else begin
					nextState = S_FETCH; // NOP, EI, DI, RETI, unknown
				end
			end
			S_IMM: nextState = S_FETCH;
			S_LO: nextState = S_HI;
			S_HI: begin
				if ((ir.raw == OP_LD_MEM_A) || (ir.raw == OP_LD_A_MEM))
					nextState = S_MEM;
				else if (jpTaken)
					nextState = S_JUMP;
				else
					nextState = S_FETCH; // Untaken, pc already past operand
			end
			S_MEM: nextState = S_FETCH;
			S_JUMP: nextState = S_FETCH;
			S_HALT: begin
				if (wakeAny)
					nextState = S_FETCH; // Dispatch, if any, happens there
			end
			S_VEC: nextState = S_FETCH;
			default: nextState = S_BOOT;
		endcase
	end

	always_comb begin
		bus = '0;
		bus.addr = pc;
		bus.wdata = accA;
		irqTaken = 1'b0;
		case (state)
			S_FETCH: begin
				if (dispatch) begin
					irqTaken = 1'b1; // No bus cycle during ack
				end else begin
					bus.rd = 1'b1;
					bus.m1 = 1'b1;
				end
			end
			S_IMM, S_LO, S_HI: bus.rd = 1'b1; // Operand bytes at pc
			S_MEM: begin
				bus.addr = tgt;
				bus.rd = (ir.raw == OP_LD_A_MEM);
				bus.wr = (ir.raw == OP_LD_MEM_A);
			end
			default: bus.rd = 1'b0; // Boot, jump, halt, vector
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= S_BOOT;
			pc <= `RESET_PC;
			ime <= 1'b0;
			accA <= 8'd0;
			flags <= '0;
		end else begin
			state <= nextState;
			case (state)
				S_FETCH: begin
					if (dispatch) begin
						ime <= 1'b0; // No nesting until RETI or EI
					end else begin
						pc <= pc + 16'd1;
						case (fetchOp.raw)
							OP_EI: ime <= 1'b1;
							OP_DI: ime <= 1'b0;
							OP_RETI: begin
								pc <= shadowPc;
								ime <= 1'b1;
							end
							default: ime <= ime;
						endcase
					end
				end
				S_IMM: begin
					pc <= pc + 16'd1;
					if (ir.raw == OP_LD_A_N) begin
						accA <= rdata;
					end else begin
						flags <= aluFlags;
						if (aluOp != sm83Pkg::ALU_CP)
							accA <= aluRes; // CP keeps A
					end
				end
				S_LO, S_HI: pc <= pc + 16'd1;
				S_MEM: begin
					if (ir.raw == OP_LD_A_MEM)
						accA <= rdata;
				end
				S_JUMP: pc <= tgt;
				S_VEC: pc <= vector;
				default: pc <= pc;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == S_FETCH) begin
			if (dispatch) begin
				shadowPc <= pc; // Next instruction, not yet fetched
				vecLine <= irq.line;
			end else begin
				ir <= fetchOp;
			end
		end
		if (state == S_LO)
			tgt[7:0] <= rdata;
		if (state == S_HI)
			tgt[15:8] <= rdata;
	end

endmodule

// File: verilog/sm83Pkg.sv
package sm83Pkg;

	// Memory request driven by the core each cycle
	typedef struct packed {
		logic [15:0] addr;  // Byte address
		logic [7:0]  wdata; // Store data, valid with wr
		logic        rd;    // Read strobe, data back same cycle
		logic        wr;    // Write strobe
		logic        m1;    // Opcode fetch cycle
	} busReq_t;

	// F register, upper nibble only
	typedef struct packed {
		logic z; // Result zero
		logic n; // Last op was a subtract
		logic h; // Carry/borrow out of bit 3
		logic c; // Carry/borrow out of bit 7
	} aluFlags_t;

	// Opcode byte, seen whole or split into x/y/z octal fields
	typedef union packed {
		logic [7:0] raw; // Exact opcode match
		struct packed {
			logic [1:0] x; // Opcode group
			logic [2:0] y; // ALU op in group 3
			logic [2:0] z; // 6 selects immediate operand
		} f;
	} opcode_u;

	// Encoded as the y field of the immediate ALU opcodes
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd4,
		ALU_XOR = 3'd5,
		ALU_OR  = 3'd6,
		ALU_CP  = 3'd7
	} aluOp_t;

	// Winning interrupt from the priority encoder
	typedef struct packed {
		logic       req;  // Some enabled line pending
		logic [2:0] line; // Lowest pending enabled line
	} irqVec_t;

endpackage

// File: verilog/sm83Subsystem.sv
`timescale 1ns/1ps
`include "sm83_macros.svh"

module sm83Subsystem (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic [7:0]            dataIn,  // Memory read data
	input  logic [`IRQ_LINES-1:0] irqTrig, // Rising edge requests
	output logic [15:0]           addr,
	output logic [7:0]            dataOut,
	output logic                  rd,
	output logic                  wr,
	output logic                  m1,
	output logic                  halted,
	output logic [`IRQ_LINES-1:0] irqAck
);

	sm83Pkg::busReq_t       bus;
	sm83Pkg::irqVec_t       irq;
	logic [7:0]             coreRdata;
	logic [7:0]             regRdata;
	logic [`IRQ_LINES-1:0]  ieBits;
	logic [`IRQ_LINES-1:0]  ifBits;   // Channel pending flags
	logic [`IRQ_LINES-1:0]  ifWdata;
	logic                   ifWrite;
	logic                   hit;
	logic                   irqTaken;
	logic                   wakeAny;

	assign coreRdata = hit ? regRdata : dataIn; // IE/IF shadow memory

	// IE/IF writes stay visible outside
	assign addr = bus.addr;
	assign dataOut = bus.wdata;
	assign rd = bus.rd;
	assign wr = bus.wr;
	assign m1 = bus.m1;

	sm83Core core (
		.CLK(CLK),
		.rst(rst),
		.rdata(coreRdata),
		.irq(irq),
		.wakeAny(wakeAny),
		.bus(bus),
		.irqTaken(irqTaken),
		.halted(halted)
	);

	irqRegs regs (
		.CLK(CLK),
		.rst(rst),
		.bus(bus),
		.ifBits(ifBits),
		.ieBits(ieBits),
		.ifWrite(ifWrite),
		.ifWdata(ifWdata),
		.hit(hit),
		.rdata(regRdata)
	);

	for (genvar i = 0; i < `IRQ_LINES; i++) begin : genChan
		irqChannel chan (
			.CLK(CLK),
			.rst(rst),
			.trig(irqTrig[i]),
			.ifWrite(ifWrite),
			.ifWbit(ifWdata[i]),
			.ack(irqAck[i]), // Same pulse seen outside
			.pending(ifBits[i])
		);
	end

	irqPriority prio (
		.pending(ifBits),
		.ieBits(ieBits),
		.irqTaken(irqTaken),
		.irq(irq),
		.wakeAny(wakeAny),
		.ack(irqAck)
	);

endmodule

// File: verilog/sm83_macros.svh
`ifndef SM83_MACROS_SVH
`define SM83_MACROS_SVH

// Interrupt sources, one IE and IF bit each
`define IRQ_LINES 8

// Interrupt enable register, top of the address map
`define IE_ADDR 16'hFFFF

// Interrupt flag register in the IO page
`define IF_ADDR 16'hFF0F

// Vector of line n sits at VECTOR_BASE + 8*n
`define VECTOR_BASE 16'h0040

// First opcode fetch after reset
`define RESET_PC 16'h0000

`endif
